/* Makefile */
# Verilator build and run for the padding DMA testbench

VERILATOR ?= verilator
TOP       ?= tb_pad_dma
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Simulation passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the search, so a failing run fails the target
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+src
src/pad_dma_pkg.sv
src/tile_walker.sv
src/pad_buffer.sv
src/burst_ctrl.sv
src/pad_dma_top.sv
tests/axi_mem_model.sv
tests/tb_pad_dma.sv

/* src/burst_ctrl.sv */
// ########################################
// Per-tile AXI read and write sequencer
// Address generation, buffer control
// ########################################

`include "pad_dma_defs.svh"

module burst_ctrl import pad_dma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tile_valid_i,
    input  dim_t       tile_x_i,
    input  dim_t       tile_y_i,
    input  edge_t      tile_edges_i,
    input  dim_t       job_width_i,
    input  addr_t      job_src_i,
    input  addr_t      job_dst_i,
    input  logic       arready_i,
    input  word_t      rdata_i,
    input  logic       rlast_i,
    input  logic       rvalid_i,
    input  logic       awready_i,
    input  logic       wready_i,
    input  logic       bvalid_i,
    input  word_t      buf_rd_data_i,
    output logic       tile_done_o,
    output addr_t      araddr_o,
    output logic       arvalid_o,
    output logic       rready_o,
    output addr_t      awaddr_o,
    output logic [3:0] awlen_o,
    output logic       awvalid_o,
    output word_t      wdata_o,
    output logic       wlast_o,
    output logic       wvalid_o,
    output logic       bready_o,
    output logic       buf_wr_en_o,
    output pos_t       buf_wr_row_o,
    output pos_t       buf_wr_col_o,
    output word_t      buf_wr_data_o,
    output logic       pad_start_o,
    output pos_t       buf_rd_row_o,
    output pos_t       buf_rd_col_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_AR,
        S_R,
        S_PAD,
        S_AW,
        S_W,
        S_B
    } state_t;

    state_t     state;
    pos_t       row_cnt;    // Read row 0..3 or output row 0..5
    pos_t       beat_cnt;   // Beat within the current burst
    logic [1:0] pad_cnt;
    logic       tile_done_q;

    logic  ar_hs;
    logic  r_hs;
    logic  aw_hs;
    logic  w_hs;
    logic  b_hs;
    pos_t  out_rows;
    pos_t  out_len;
    addr_t src_row;
    addr_t src_col;
    addr_t dst_row;
    addr_t dst_col;

    assign ar_hs = arvalid_o && arready_i;
    assign r_hs  = rvalid_i && rready_o;
    assign aw_hs = awvalid_o && awready_i;
    assign w_hs  = wvalid_o && wready_i;
    assign b_hs  = bvalid_i && bready_o;

    // One extra row or column per touched edge
    assign out_rows = pos_t'(`PAD_TILE) + pos_t'(tile_edges_i.top) + pos_t'(tile_edges_i.bottom);
    assign out_len  = pos_t'(`PAD_TILE) + pos_t'(tile_edges_i.left) + pos_t'(tile_edges_i.right);

    assign src_row = addr_t'(tile_y_i) * `PAD_TILE + addr_t'(row_cnt);
    assign src_col = addr_t'(tile_x_i) * `PAD_TILE;
    assign araddr_o = job_src_i + (src_row * addr_t'(job_width_i) + src_col) * `PAD_BYTES;

    // Interior tiles start one row and one column into the padded matrix
    assign dst_row = addr_t'(tile_y_i) * `PAD_TILE + addr_t'(!tile_edges_i.top)
                   + addr_t'(row_cnt);
    assign dst_col = addr_t'(tile_x_i) * `PAD_TILE + addr_t'(!tile_edges_i.left);
    assign awaddr_o = job_dst_i
                    + (dst_row * (addr_t'(job_width_i) + 2) + dst_col) * `PAD_BYTES;
    assign awlen_o  = {1'b0, out_len - pos_t'(1)};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            row_cnt     <= '0;
            beat_cnt    <= '0;
            pad_cnt     <= '0;
            tile_done_q <= 1'b0;
        end else begin
            tile_done_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    // Old tile is still offered during the done pulse
                    if (tile_valid_i && !tile_done_q) begin
                        row_cnt  <= '0;
                        beat_cnt <= '0;
                        state    <= S_AR;
                    end
                end
                S_AR: begin
                    if (ar_hs) begin
                        state <= S_R;
                    end
                end
                S_R: begin
                    if (r_hs) begin
                        if (rlast_i) begin
                            beat_cnt <= '0;
                            if (row_cnt == pos_t'(`PAD_TILE - 1)) begin
                                row_cnt <= '0;
                                pad_cnt <= '0;
                                state   <= S_PAD;
                            end else begin
                                row_cnt <= row_cnt + pos_t'(1);
                                state   <= S_AR;
                            end
                        end else begin
                            beat_cnt <= beat_cnt + pos_t'(1);
                        end
                    end
                end
                S_PAD: begin
                    pad_cnt <= pad_cnt + 2'd1;   // Start pulse, then two pad cycles
                    if (pad_cnt == 2'd2) begin
                        state <= S_AW;
                    end
                end
                S_AW: begin
                    if (aw_hs) begin
                        state <= S_W;
                    end
                end
                S_W: begin
                    if (w_hs) begin
                        if (wlast_o) begin
                            beat_cnt <= '0;
                            state    <= S_B;
                        end else begin
                            beat_cnt <= beat_cnt + pos_t'(1);
                        end
                    end
                end
                S_B: begin
                    if (b_hs) begin
                        if (row_cnt == out_rows - pos_t'(1)) begin
                            row_cnt     <= '0;
                            tile_done_q <= 1'b1;
                            state       <= S_IDLE;
                        end else begin
                            row_cnt <= row_cnt + pos_t'(1);
                            state   <= S_AW;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign arvalid_o = (state == S_AR);
    assign rready_o  = (state == S_R);
    assign awvalid_o = (state == S_AW);
    assign wvalid_o  = (state == S_W);
    assign bready_o  = (state == S_B);
    assign wlast_o   = (state == S_W) && (beat_cnt == out_len - pos_t'(1));
    assign wdata_o   = buf_rd_data_i;

    // Every R beat goes straight into the buffer
    assign buf_wr_en_o   = r_hs;
    assign buf_wr_row_o  = row_cnt;
    assign buf_wr_col_o  = beat_cnt;
    assign buf_wr_data_o = rdata_i;

    assign pad_start_o  = (state == S_PAD) && (pad_cnt == 2'd0);
    assign buf_rd_row_o = row_cnt;
    assign buf_rd_col_o = beat_cnt;
    assign tile_done_o  = tile_done_q;

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else $error("AR request dropped before acceptance");

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o) && $stable(awlen_o))
        else $error("AW request dropped before acceptance");

endmodule

/* src/pad_buffer.sv */
// ########################################
// 6x6 tile buffer with offset writes,
// two-step edge replication, comb read
// ########################################

`include "pad_dma_defs.svh"

module pad_buffer import pad_dma_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  edge_t edges_i,
    input  logic  wr_en_i,
    input  pos_t  wr_row_i,
    input  pos_t  wr_col_i,
    input  word_t wr_data_i,
    input  logic  pad_start_i,
    input  pos_t  rd_row_i,
    input  pos_t  rd_col_i,
    output word_t rd_data_o
);

    word_t buf_mem [`PAD_BUF][`PAD_BUF];

    logic  pad_col_q;   // First pad cycle, columns
    logic  pad_row_q;   // Second pad cycle, rows
    pos_t  wr_r;
    pos_t  wr_c;
    pos_t  right_pad;
    pos_t  right_in;
    pos_t  bot_pad;
    pos_t  bot_in;

    // Leave room for the top row and left column when they are padded
    assign wr_r = wr_row_i + pos_t'(edges_i.top);
    assign wr_c = wr_col_i + pos_t'(edges_i.left);

    // Right and bottom pad lines sit just past the stored tile
    assign right_pad = pos_t'(`PAD_TILE) + pos_t'(edges_i.left);
    assign right_in  = pos_t'(`PAD_TILE - 1) + pos_t'(edges_i.left);
    assign bot_pad   = pos_t'(`PAD_TILE) + pos_t'(edges_i.top);
    assign bot_in    = pos_t'(`PAD_TILE - 1) + pos_t'(edges_i.top);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pad_col_q <= 1'b0;
            pad_row_q <= 1'b0;
        end else begin
            pad_col_q <= pad_start_i;
            pad_row_q <= pad_col_q;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            buf_mem[wr_r][wr_c] <= wr_data_i;
        end else if (pad_col_q) begin
            // All six rows, so the pad rows carry the corner values too
            for (int r = 0; r < `PAD_BUF; r++) begin
                if (edges_i.left) begin
                    buf_mem[r][0] <= buf_mem[r][1];
                end
                if (edges_i.right) begin
                    buf_mem[r][right_pad] <= buf_mem[r][right_in];
                end
            end
        end else if (pad_row_q) begin
            // Whole rows, corners get the diagonal element
            for (int c = 0; c < `PAD_BUF; c++) begin
                if (edges_i.top) begin
                    buf_mem[0][c] <= buf_mem[1][c];
                end
                if (edges_i.bottom) begin
                    buf_mem[bot_pad][c] <= buf_mem[bot_in][c];
                end
            end
        end
    end

    assign rd_data_o = buf_mem[rd_row_i][rd_col_i];

    // Sequencer keeps R data away from the replication cycles
    a_no_wr_pad: assert property (@(posedge clk) disable iff (!rst_n)
        (pad_col_q || pad_row_q) |-> !wr_en_i)
        else $error("buffer write during padding");

endmodule

/* src/pad_dma_defs.svh */
// ########################################
// Width, tile and buffer size macros
// for the edge-padding DMA engine
// ########################################

`ifndef PAD_DMA_DEFS_SVH
`define PAD_DMA_DEFS_SVH

`define PAD_DATA_W  32  // Data word bits
`define PAD_ADDR_W  32  // Byte address bits

`define PAD_TILE    4   // Tile side in words
`define PAD_BUF     6   // Tile plus one pad element per side

`define PAD_DIM_W   6   // Matrix width field, up to 60
`define PAD_BYTES   4   // Bytes per data word

`endif

/* src/pad_dma_pkg.sv */
// ########################################
// Shared types of the padding DMA engine
// Words, addresses, dimensions, edges
// ########################################

`include "pad_dma_defs.svh"

package pad_dma_pkg;

    // One data word on the AXI buses
    typedef logic [`PAD_DATA_W-1:0] word_t;

    // Byte address
    typedef logic [`PAD_ADDR_W-1:0] addr_t;

    // Matrix width or tile index
    typedef logic [`PAD_DIM_W-1:0] dim_t;

    // Row or column inside the 6x6 tile buffer
    typedef logic [2:0] pos_t;

    // Matrix edges touched by the current tile
    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } edge_t;

endpackage

/* src/pad_dma_top.sv */
// ########################################
// Padding DMA top level
// Walker, tile buffer and AXI sequencer
// ########################################

module pad_dma_top import pad_dma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  addr_t      src_addr_i,
    input  addr_t      dst_addr_i,
    input  dim_t       mat_width_i,
    output logic       done_o,
    output addr_t      araddr_o,
    output logic       arvalid_o,
    input  logic       arready_i,
    input  word_t      rdata_i,
    input  logic       rlast_i,
    input  logic       rvalid_i,
    output logic       rready_o,
    output addr_t      awaddr_o,
    output logic [3:0] awlen_o,
    output logic       awvalid_o,
    input  logic       awready_i,
    output word_t      wdata_o,
    output logic       wlast_o,
    output logic       wvalid_o,
    input  logic       wready_i,
    input  logic       bvalid_i,
    output logic       bready_o
);

    // Walker to sequencer
    logic  tile_valid;
    dim_t  tile_x;
    dim_t  tile_y;
    edge_t tile_edges;
    dim_t  job_width;
    addr_t job_src;
    addr_t job_dst;
    logic  tile_done;

    // Sequencer to buffer
    logic  buf_wr_en;
    pos_t  buf_wr_row;
    pos_t  buf_wr_col;
    word_t buf_wr_data;
    logic  pad_start;
    pos_t  buf_rd_row;
    pos_t  buf_rd_col;
    word_t buf_rd_data;

    tile_walker u_walker (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .mat_width_i  (mat_width_i),
        .tile_done_i  (tile_done),
        .done_o       (done_o),
        .tile_valid_o (tile_valid),
        .tile_x_o     (tile_x),
        .tile_y_o     (tile_y),
        .tile_edges_o (tile_edges),
        .job_width_o  (job_width),
        .job_src_o    (job_src),
        .job_dst_o    (job_dst)
    );

    pad_buffer u_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .edges_i     (tile_edges),
        .wr_en_i     (buf_wr_en),
        .wr_row_i    (buf_wr_row),
        .wr_col_i    (buf_wr_col),
        .wr_data_i   (buf_wr_data),
        .pad_start_i (pad_start),
        .rd_row_i    (buf_rd_row),
        .rd_col_i    (buf_rd_col),
        .rd_data_o   (buf_rd_data)
    );

    burst_ctrl u_burst (
        .clk           (clk),
        .rst_n         (rst_n),
        .tile_valid_i  (tile_valid),
        .tile_x_i      (tile_x),
        .tile_y_i      (tile_y),
        .tile_edges_i  (tile_edges),
        .job_width_i   (job_width),
        .job_src_i     (job_src),
        .job_dst_i     (job_dst),
        .arready_i     (arready_i),
        .rdata_i       (rdata_i),
        .rlast_i       (rlast_i),
        .rvalid_i      (rvalid_i),
        .awready_i     (awready_i),
        .wready_i      (wready_i),
        .bvalid_i      (bvalid_i),
        .buf_rd_data_i (buf_rd_data),
        .tile_done_o   (tile_done),
        .araddr_o      (araddr_o),
        .arvalid_o     (arvalid_o),
        .rready_o      (rready_o),
        .awaddr_o      (awaddr_o),
        .awlen_o       (awlen_o),
        .awvalid_o     (awvalid_o),
        .wdata_o       (wdata_o),
        .wlast_o       (wlast_o),
        .wvalid_o      (wvalid_o),
        .bready_o      (bready_o),
        .buf_wr_en_o   (buf_wr_en),
        .buf_wr_row_o  (buf_wr_row),
        .buf_wr_col_o  (buf_wr_col),
        .buf_wr_data_o (buf_wr_data),
        .pad_start_o   (pad_start),
        .buf_rd_row_o  (buf_rd_row),
        .buf_rd_col_o  (buf_rd_col)
    );

endmodule

/* src/tile_walker.sv */
// ########################################
// Job acceptance and row-major tile walk
// with edge flags and completion flag
// ########################################

`include "pad_dma_defs.svh"

module tile_walker import pad_dma_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start_i,
    input  addr_t src_addr_i,
    input  addr_t dst_addr_i,
    input  dim_t  mat_width_i,
    input  logic  tile_done_i,
    output logic  done_o,
    output logic  tile_valid_o,
    output dim_t  tile_x_o,
    output dim_t  tile_y_o,
    output edge_t tile_edges_o,
    output dim_t  job_width_o,
    output addr_t job_src_o,
    output addr_t job_dst_o
);

    logic  done_q;
    logic  tile_valid_q;
    logic  next_pend_q;   // Gap cycle between two tiles
    dim_t  tile_x_q;
    dim_t  tile_y_q;
    dim_t  last_idx_q;    // Tiles per side minus one
    logic  width_ok;
    logic  accept;
    logic  last_x;
    logic  last_y;

    // Nonzero and a multiple of the tile side
    assign width_ok = (mat_width_i != '0) && (mat_width_i[1:0] == 2'b00);
    assign accept   = done_q && start_i && width_ok;

    assign last_x = (tile_x_q == last_idx_q);
    assign last_y = (tile_y_q == last_idx_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q       <= 1'b1;
            tile_valid_q <= 1'b0;
            next_pend_q  <= 1'b0;
            tile_x_q     <= '0;
            tile_y_q     <= '0;
        end else begin
            next_pend_q <= 1'b0;
            if (accept) begin
                done_q       <= 1'b0;
                tile_valid_q <= 1'b1;
                tile_x_q     <= '0;
                tile_y_q     <= '0;
            end else if (tile_done_i) begin
                tile_valid_q <= 1'b0;
                if (last_x && last_y) begin
                    done_q <= 1'b1;   // Whole matrix written
                end else begin
                    next_pend_q <= 1'b1;
                    if (last_x) begin
                        tile_x_q <= '0;
                        tile_y_q <= tile_y_q + dim_t'(1);
                    end else begin
                        tile_x_q <= tile_x_q + dim_t'(1);
                    end
                end
            end else if (next_pend_q) begin
                tile_valid_q <= 1'b1;
            end
        end
    end

    // Job configuration, held for the whole walk
    always_ff @(posedge clk) begin
        if (accept) begin
            job_width_o <= mat_width_i;
            job_src_o   <= src_addr_i;
            job_dst_o   <= dst_addr_i;
            last_idx_q  <= dim_t'(mat_width_i / `PAD_TILE) - dim_t'(1);
        end
    end

    assign done_o       = done_q;
    assign tile_valid_o = tile_valid_q;
    assign tile_x_o     = tile_x_q;
    assign tile_y_o     = tile_y_q;

    assign tile_edges_o.top    = (tile_y_q == '0);
    assign tile_edges_o.bottom = last_y;
    assign tile_edges_o.left   = (tile_x_q == '0);
    assign tile_edges_o.right  = last_x;

    // Sequencer must only finish a tile that is on offer
    a_done_in_tile: assert property (@(posedge clk) disable iff (!rst_n)
        tile_done_i |-> tile_valid_o)
        else $error("tile_done without tile_valid");

endmodule

/* tests/axi_mem_model.sv */
// ########################################
// AXI slave memory with random stalls
// and a backdoor port for load and read
// ########################################

module axi_mem_model import pad_dma_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  stall_thr_i,   // Higher means more stall cycles
    input  logic        bd_we_i,
    input  logic [11:0] bd_idx_i,
    input  word_t       bd_wdata_i,
    output word_t       bd_rdata_o,
    output logic        len_err_o,
    input  addr_t       araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output word_t       rdata_o,
    output logic        rlast_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    input  addr_t       awaddr_i,
    input  logic [3:0]  awlen_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  word_t       wdata_i,
    input  logic        wlast_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic        bvalid_o,
    input  logic        bready_i
);

    localparam int MEM_WORDS = 4096;

    word_t       mem [MEM_WORDS];
    logic [31:0] rnd;
    logic        rd_busy;
    logic [11:0] rd_idx;
    logic [1:0]  rd_beat;     // Reads are always 4-beat bursts
    logic        wr_busy;
    logic        b_pend;
    logic [11:0] wr_idx;
    logic [3:0]  wr_beat;
    logic [3:0]  wr_len;
    logic        go_ar;
    logic        go_r;
    logic        go_aw;
    logic        go_w;
    logic        go_b;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One random nibble per channel
    assign go_ar = rnd[3:0] >= stall_thr_i;
    assign go_r  = rnd[7:4] >= stall_thr_i;
    assign go_aw = rnd[11:8] >= stall_thr_i;
    assign go_w  = rnd[15:12] >= stall_thr_i;
    assign go_b  = rnd[19:16] >= stall_thr_i;

    always_ff @(posedge clk) begin
        if (bd_we_i) begin
            mem[bd_idx_i] <= bd_wdata_i;
        end else if (wvalid_i && wready_o) begin
            mem[wr_idx] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rnd       <= 32'hb709;
            rd_busy   <= 1'b0;
            rd_idx    <= '0;
            rd_beat   <= '0;
            rvalid_o  <= 1'b0;
            wr_busy   <= 1'b0;
            b_pend    <= 1'b0;
            wr_idx    <= '0;
            wr_beat   <= '0;
            wr_len    <= '0;
            bvalid_o  <= 1'b0;
            len_err_o <= 1'b0;
        end else begin
            rnd <= xorshift32(rnd);
            if (!rd_busy) begin
                if (arvalid_i && arready_o) begin
                    rd_busy <= 1'b1;
                    rd_idx  <= araddr_i[13:2];
                    rd_beat <= '0;
                end
            end else if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
                rd_idx   <= rd_idx + 12'd1;
                rd_beat  <= rd_beat + 2'd1;
                if (rlast_o) begin
                    rd_busy <= 1'b0;
                end
            end else if (!rvalid_o && go_r) begin
                rvalid_o <= 1'b1;
            end

            if (!wr_busy) begin
                if (awvalid_i && awready_o) begin
                    wr_busy <= 1'b1;
                    wr_idx  <= awaddr_i[13:2];
                    wr_beat <= '0;
                    wr_len  <= awlen_i;
                end
            end else if (wvalid_i && wready_o) begin
                wr_idx  <= wr_idx + 12'd1;
                wr_beat <= wr_beat + 4'd1;
                if (wlast_i != (wr_beat == wr_len)) begin
                    len_err_o <= 1'b1;   // wlast disagrees with awlen
                end
                if (wlast_i) begin
                    b_pend <= 1'b1;
                end
            end else if (b_pend && !bvalid_o && go_b) begin
                bvalid_o <= 1'b1;
            end else if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
                b_pend   <= 1'b0;
                wr_busy  <= 1'b0;
            end
        end
    end

    assign arready_o  = !rd_busy && go_ar;
    assign rdata_o    = mem[rd_idx];
    assign rlast_o    = (rd_beat == 2'd3);
    assign awready_o  = !wr_busy && go_aw;
    assign wready_o   = wr_busy && !b_pend && go_w;
    assign bd_rdata_o = mem[bd_idx_i];

endmodule

/* tests/tb_pad_dma.sv */
// ########################################
// Testbench for the padding DMA engine
// Jobs, reference function, compare tasks
// ########################################

module tb_pad_dma import pad_dma_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    addr_t       src_addr;
    addr_t       dst_addr;
    dim_t        mat_width;
    logic        done;
    addr_t       araddr;
    logic        arvalid;
    logic        arready;
    word_t       rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    addr_t       awaddr;
    logic [3:0]  awlen;
    logic        awvalid;
    logic        awready;
    word_t       wdata;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [3:0]  stall_thr;
    logic        bd_we;
    logic [11:0] bd_idx;
    word_t       bd_wdata;
    word_t       bd_rdata;
    logic        len_err;
    logic        done_prev;
    int          done_rises;
    int          err_cnt;
    int          tests_run;
    int          tests_failed;

    always #2 clk = ~clk;

    pad_dma_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start),
        .src_addr_i  (src_addr),
        .dst_addr_i  (dst_addr),
        .mat_width_i (mat_width),
        .done_o      (done),
        .araddr_o    (araddr),
        .arvalid_o   (arvalid),
        .arready_i   (arready),
        .rdata_i     (rdata),
        .rlast_i     (rlast),
        .rvalid_i    (rvalid),
        .rready_o    (rready),
        .awaddr_o    (awaddr),
        .awlen_o     (awlen),
        .awvalid_o   (awvalid),
        .awready_i   (awready),
        .wdata_o     (wdata),
        .wlast_o     (wlast),
        .wvalid_o    (wvalid),
        .wready_i    (wready),
        .bvalid_i    (bvalid),
        .bready_o    (bready)
    );

    axi_mem_model u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_thr_i (stall_thr),
        .bd_we_i     (bd_we),
        .bd_idx_i    (bd_idx),
        .bd_wdata_i  (bd_wdata),
        .bd_rdata_o  (bd_rdata),
        .len_err_o   (len_err),
        .araddr_i    (araddr),
        .arvalid_i   (arvalid),
        .arready_o   (arready),
        .rdata_o     (rdata),
        .rlast_o     (rlast),
        .rvalid_o    (rvalid),
        .rready_i    (rready),
        .awaddr_i    (awaddr),
        .awlen_i     (awlen),
        .awvalid_i   (awvalid),
        .awready_o   (awready),
        .wdata_i     (wdata),
        .wlast_i     (wlast),
        .wvalid_i    (wvalid),
        .wready_o    (wready),
        .bvalid_o    (bvalid),
        .bready_i    (bready)
    );

    // Rising edges of done_o
    always @(posedge clk) begin
        if (!rst_n) begin
            done_prev  <= 1'b1;
            done_rises <= 0;
        end else begin
            done_prev <= done;
            if (done && !done_prev) begin
                done_rises <= done_rises + 1;
            end
        end
    end

    function automatic word_t source_word(int job, int i, int j);
        return {job[7:0], 8'h3c, i[7:0], j[7:0]};
    endfunction

    function automatic word_t sentinel_word(int idx);
        return {8'h5e, idx[23:0]};
    endfunction

    function automatic int clamp(int v, int w);
        if (v < 0) begin
            return 0;
        end
        if (v > w - 1) begin
            return w - 1;
        end
        return v;
    endfunction

    // Padded (r,c) takes the nearest source element
    function automatic word_t expected_word(int job, int w, int r, int c);
        return source_word(job, clamp(r - 1, w), clamp(c - 1, w));
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic write_word(input int idx, input word_t val);
        @(posedge clk);
        bd_we    <= 1'b1;
        bd_idx   <= idx[11:0];
        bd_wdata <= val;
    endtask

    task automatic stop_writes;
        @(posedge clk);
        bd_we <= 1'b0;
    endtask

    task automatic read_word(input int idx, output word_t val);
        @(posedge clk);
        bd_idx <= idx[11:0];
        @(negedge clk);
        val = bd_rdata;
    endtask

    task automatic fill_memory;
        for (int a = 0; a < 4096; a++) begin
            write_word(a, sentinel_word(a));
        end
        stop_writes();
    endtask

    task automatic load_source(input int job, input addr_t base, input int w);
        int idx;
        idx = int'(base >> 2);
        for (int i = 0; i < w; i++) begin
            for (int j = 0; j < w; j++) begin
                write_word(idx + i * w + j, source_word(job, i, j));
            end
        end
        stop_writes();
    endtask

    // Whole padded area plus one word on each side of it
    task automatic compare_dest(input int job, input addr_t base, input int w,
                                input bit untouched);
        int    idx;
        int    pw;
        word_t got;
        word_t exp;
        idx = int'(base >> 2);
        pw  = w + 2;
        for (int r = 0; r < pw; r++) begin
            for (int c = 0; c < pw; c++) begin
                read_word(idx + r * pw + c, got);
                exp = untouched ? sentinel_word(idx + r * pw + c) : expected_word(job, w, r, c);
                check_word($sformatf("dst[%0d][%0d]", r, c), got, exp);
            end
        end
        read_word(idx - 1, got);
        check_word("word before destination", got, sentinel_word(idx - 1));
        read_word(idx + pw * pw, got);
        check_word("word after destination", got, sentinel_word(idx + pw * pw));
    endtask

    task automatic start_job(input addr_t src, input addr_t dst, input int w);
        @(posedge clk);
        src_addr  <= src;
        dst_addr  <= dst;
        mat_width <= dim_t'(w);
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input int limit, output bit ok);
        int n;
        n = 0;
        while (!done && n < limit) begin
            @(negedge clk);
            n++;
        end
        ok = done;
        if (!ok) begin
            err_cnt++;
            $display("Timeout: done_o stayed low for %0d cycles", limit);
        end
    endtask

    task automatic run_job(input int job, input addr_t src, input addr_t dst, input int w,
                           output bit ok);
        load_source(job, src, w);
        start_job(src, dst, w);
        @(negedge clk);
        check_flag("done_o after start", done, 1'b0);   // Falls one cycle after start
        wait_done(TIMEOUT_CYCLES, ok);
        if (ok) begin
            compare_dest(job, dst, w, 1'b0);
            check_flag("wlast against awlen error", len_err, 1'b0);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, err_cnt - errs_before);
        end
    endtask

    task automatic run_tests;
        int e;
        int rises;
        bit ok;

        e = err_cnt;
        @(negedge clk);
        check_flag("done_o", done, 1'b1);
        check_flag("arvalid_o", arvalid, 1'b0);
        check_flag("rready_o", rready, 1'b0);
        check_flag("awvalid_o", awvalid, 1'b0);
        check_flag("wvalid_o", wvalid, 1'b0);
        check_flag("bready_o", bready, 1'b0);
        fill_memory();
        start_job(32'h0000, 32'h2000, 6);
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            check_flag("done_o", done, 1'b1);
            check_flag("arvalid_o", arvalid, 1'b0);
        end
        compare_dest(1, 32'h2000, 6, 1'b1);
        finish_test("reset and rejected width 6", e);

        e = err_cnt;
        run_job(2, 32'h0000, 32'h2400, 4, ok);
        finish_test("width 4, all edges", e);
        if (!ok) return;

        e = err_cnt;
        run_job(3, 32'h0100, 32'h2800, 12, ok);
        finish_test("width 12, nine tiles", e);
        if (!ok) return;

        e = err_cnt;
        @(posedge clk);
        stall_thr <= 4'd11;   // Channels ready about a third of the time
        rises = done_rises;
        run_job(4, 32'h0400, 32'h3000, 8, ok);
        if (ok && done_rises - rises != 1) begin
            err_cnt++;
            $display("done_o rose %0d times during the job instead of once",
                     done_rises - rises);
        end
        @(posedge clk);
        stall_thr <= 4'd3;
        finish_test("width 8, heavy stalls", e);
        if (!ok) return;

        e = err_cnt;
        run_job(5, 32'h0800, 32'h3400, 16, ok);
        finish_test("second job, width 16", e);
    endtask

    initial begin
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n     <= 1'b0;
        start     <= 1'b0;
        src_addr  <= '0;
        dst_addr  <= '0;
        mat_width <= '0;
        stall_thr <= 4'd3;
        bd_we     <= 1'b0;
        bd_idx    <= '0;
        bd_wdata  <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        run_tests();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
